//--- build.f
fm_pkg.sv
op_stream_if.sv
fm_regs.sv
fm_operator_engine.sv
fm_sample_fifo.sv
fm_mixer.sv
fmsynth.sv
tb_fmsynth.sv

//--- Makefile
TOP := tb_fmsynth
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wno-fatal fm_pkg.sv op_stream_if.sv fm_regs.sv \
		fm_operator_engine.sv fm_sample_fifo.sv fm_mixer.sv fmsynth.sv --top-module fmsynth
	verilator --lint-only --timing -Wno-fatal -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) \
		-Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_fmsynth.sv
`timescale 1ns/1ps

module tb_fmsynth;

    localparam int num_channels = 8;
    localparam int sample_div   = 64;
    localparam int fifo_depth   = 8;
    localparam int frame_len    = 4 * num_channels;
    localparam int mod_ch       = 3;
    // About 40 frames of tests, 8 frames of margin
    localparam int max_cycles   = (40 + 8) * sample_div;

    // Stored field positions of the channel and operator words
    localparam logic [31:0] ch_mask = 32'h0031_1fff;
    localparam logic [31:0] op_mask = 32'h0000_0ff1;

    logic        clk = 1'b0;
    logic        reset;
    logic [7:0]  bus_addr;
    logic [31:0] bus_wrdata;
    logic        bus_wren;
    logic [31:0] bus_rddata;
    logic        bus_wait;
    logic [15:0] audio_l;
    logic [15:0] audio_r;

    string       test_name = "reset";
    logic        rd_check = 1'b0;
    logic [31:0] rd_expect = '0;
    logic        aud_check = 1'b0;
    logic [15:0] exp_l = '0;
    logic [15:0] exp_r = '0;
    logic        stall_check = 1'b0;
    int          last_stall = 0;
    int          wait_run = 0;
    int          cycles = 0;
    int          err_rd = 0;
    int          err_wait = 0;
    int          err_bound = 0;
    int          err_stall = 0;
    int          err_aud = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_before = 0;
    integer      seed = 84;
    logic [1:0]  pan_sel [num_channels];

    fmsynth #(
        .num_channels(num_channels),
        .sample_div  (sample_div),
        .fifo_depth  (fifo_depth)
    ) u_fmsynth (
        .clk       (clk),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_wrdata(bus_wrdata),
        .bus_wren  (bus_wren),
        .bus_rddata(bus_rddata),
        .bus_wait  (bus_wait),
        .audio_l   (audio_l),
        .audio_r   (audio_r)
    );

    always #20 clk = ~clk;

    // Length of the current bus_wait run
    always @(posedge clk) begin
        wait_run <= bus_wait ? wait_run + 1 : 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    a_readback: assert property (@(posedge clk) disable iff (reset)
        rd_check |-> bus_rddata == rd_expect)
        else begin
            err_rd++;
            $display("Error %s: readback at 0x%02h expected 0x%08h, actual 0x%08h",
                     test_name, bus_addr, rd_expect, bus_rddata);
        end

    a_wait_wren: assert property (@(posedge clk) disable iff (reset)
        bus_wait |-> bus_wren)
        else begin
            err_wait++;
            $display("Error %s: bus_wait went high with no write on the bus", test_name);
        end

    // A stall never outlasts one frame
    a_wait_bound: assert property (@(posedge clk) disable iff (reset)
        bus_wait |-> wait_run < frame_len)
        else begin
            err_bound++;
            $display("Error %s: stall length expected below %0d, actual %0d",
                     test_name, frame_len, wait_run);
        end

    a_stall_seen: assert property (@(posedge clk) disable iff (reset)
        stall_check |-> last_stall > 0)
        else begin
            err_stall++;
            $display("Error %s: no write was stalled by a frame in progress", test_name);
        end

    a_audio: assert property (@(posedge clk) disable iff (reset)
        aud_check |-> audio_l == exp_l && audio_r == exp_r)
        else begin
            err_aud++;
            $display("Error %s: audio expected l=%0d r=%0d, actual l=%0d r=%0d", test_name,
                     $signed(exp_l), $signed(exp_r), $signed(audio_l), $signed(audio_r));
        end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic int total_errors();
        return err_rd + err_wait + err_bound + err_stall + err_aud;
    endfunction

    function automatic logic [31:0] ch_word(input logic [9:0] fnum, input logic [2:0] block,
                                            input logic alg, input logic pl, input logic pr);
        return {10'b0, pr, pl, 3'b0, alg, 3'b0, block, fnum};
    endfunction

    function automatic logic [31:0] op_word(input logic wave, input logic [3:0] mult,
                                            input logic [3:0] tl);
        return {20'b0, tl, mult, 3'b0, wave};
    endfunction

    function automatic int square_amp(input logic [3:0] tl);
        return 4095 >> tl;
    endfunction

    function automatic logic [15:0] clamp_audio(input int v);
        if (v > 32767)
            return 16'h7fff;
        if (v < -32768)
            return 16'h8000;
        return 16'(v);
    endfunction

    // Drive a write and ride out any stall
    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        bus_addr   = addr;
        bus_wrdata = data;
        bus_wren   = 1'b1;
        last_stall = 0;
        // Stall decision for the coming edge
        @(negedge clk);
        while (bus_wait) begin
            last_stall++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        bus_wren = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] value);
        bus_addr  = addr;
        rd_expect = value;
        rd_check  = 1'b1;
        @(posedge clk);
        #1;
        rd_check = 1'b0;
    endtask

    // Three frames settle any latency before sampling
    task automatic audio_check(input logic [15:0] l, input logic [15:0] r);
        repeat (3 * sample_div) @(posedge clk);
        #1;
        exp_l     = l;
        exp_r     = r;
        aud_check = 1'b1;
        @(posedge clk);
        #1;
        aud_check = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = total_errors();
        tests_run++;
    endtask

    task automatic end_test();
        if (total_errors() == errors_before) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed, %0d errors", test_name, total_errors() - errors_before);
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        logic [31:0] data;
        logic [3:0]  tl;
        int          sum_l;
        int          sum_r;
        int          op1;
        logic [9:0]  mod_phase;

        reset      = 1'b1;
        bus_addr   = '0;
        bus_wrdata = '0;
        bus_wren   = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        begin_test("register readback");
        for (int c = 0; c < num_channels; c++) begin
            data = $random(seed);
            bus_write(fm_pkg::ch_base + 8'(c), data);
            read_check(fm_pkg::ch_base + 8'(c), data & ch_mask);
        end
        for (int o = 0; o < 2 * num_channels; o++) begin
            data = $random(seed);
            bus_write(fm_pkg::op_base + 8'(o), data);
            read_check(fm_pkg::op_base + 8'(o), data & op_mask);
        end
        data = $random(seed);
        bus_write(fm_pkg::addr_kon, data);
        read_check(fm_pkg::addr_kon, data);
        end_test();

        begin_test("bus stall");
        // Back to back writes until one lands in a frame
        last_stall = 0;
        for (int i = 0; i < sample_div && last_stall == 0; i++) begin
            data = $random(seed);
            bus_write(fm_pkg::ch_base, data);
        end
        stall_check = 1'b1;
        @(posedge clk);
        #1;
        stall_check = 1'b0;
        read_check(fm_pkg::ch_base, data & ch_mask);
        end_test();

        begin_test("silence");
        bus_write(fm_pkg::addr_kon, 32'h0);
        audio_check(16'h0, 16'h0);
        end_test();

        begin_test("additive square");
        sum_l = 0;
        sum_r = 0;
        for (int c = 0; c < num_channels; c++) begin
            pan_sel[c] = 2'($random(seed));
            bus_write(fm_pkg::ch_base + 8'(c),
                      ch_word(10'd0, 3'($random(seed)), 1'b1, pan_sel[c][0], pan_sel[c][1]));
        end
        for (int o = 0; o < 2 * num_channels; o++) begin
            tl = 4'($random(seed));
            bus_write(fm_pkg::op_base + 8'(o), op_word(1'b1, 4'($random(seed)), tl));
            if (pan_sel[o / 2][0])
                sum_l += square_amp(tl);
            if (pan_sel[o / 2][1])
                sum_r += square_amp(tl);
        end
        // Rising keys restart every phase at zero
        bus_write(fm_pkg::addr_kon, (32'd1 << num_channels) - 1);
        audio_check(clamp_audio(sum_l), clamp_audio(sum_r));
        end_test();

        begin_test("saturation");
        sum_l = 0;
        for (int c = 0; c < num_channels; c++)
            bus_write(fm_pkg::ch_base + 8'(c), ch_word(10'd0, 3'd0, 1'b1, 1'b1, 1'b1));
        for (int o = 0; o < 2 * num_channels; o++) begin
            bus_write(fm_pkg::op_base + 8'(o), op_word(1'b1, 4'd1, 4'd0));
            sum_l += square_amp(4'd0);
        end
        audio_check(clamp_audio(sum_l), clamp_audio(sum_l));
        end_test();

        begin_test("modulation");
        bus_write(fm_pkg::ch_base + 8'(mod_ch), ch_word(10'd0, 3'd0, 1'b0, 1'b1, 1'b0));
        bus_write(fm_pkg::op_base + 8'(2 * mod_ch), op_word(1'b1, 4'd1, 4'd0));
        bus_write(fm_pkg::op_base + 8'(2 * mod_ch + 1), op_word(1'b1, 4'd1, 4'd0));
        bus_write(fm_pkg::addr_kon, 32'd1 << mod_ch);
        // Operator 0 sits at phase zero, its low bits shift operator 1
        mod_phase = 10'(square_amp(4'd0));
        op1       = mod_phase[9] ? -square_amp(4'd0) : square_amp(4'd0);
        audio_check(clamp_audio(op1), 16'h0);
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- fmsynth.sv
`timescale 1ns/1ps

module fmsynth #(
    parameter int num_channels = 8,
    parameter int sample_div   = 64,
    parameter int fifo_depth   = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [7:0]                 bus_addr,
    input  logic [31:0]                bus_wrdata,
    input  logic                       bus_wren,
    output logic [31:0]                bus_rddata,
    output logic                       bus_wait,
    output logic [fm_pkg::audio_w-1:0] audio_l,
    output logic [fm_pkg::audio_w-1:0] audio_r
);

    localparam int op_w = $clog2(2 * num_channels);

    logic [op_w-1:0]  op_sel;
    logic             frame_busy;
    logic             frame_done;
    fm_pkg::ch_attr_t ch_attr;
    fm_pkg::op_attr_t op_attr;
    logic             key_on;
    logic             restart;

    // Engine to FIFO, FIFO to mixer
    op_stream_if eng_stream ();
    op_stream_if mix_stream ();

    fm_regs #(.num_channels(num_channels)) u_regs (
        .clk       (clk),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_wrdata(bus_wrdata),
        .bus_wren  (bus_wren),
        .bus_rddata(bus_rddata),
        .bus_wait  (bus_wait),
        .op_sel    (op_sel),
        .frame_busy(frame_busy),
        .frame_done(frame_done),
        .ch_attr   (ch_attr),
        .op_attr   (op_attr),
        .key_on    (key_on),
        .restart   (restart)
    );

    fm_operator_engine #(
        .num_channels(num_channels),
        .sample_div  (sample_div)
    ) u_engine (
        .clk       (clk),
        .reset     (reset),
        .ch_attr   (ch_attr),
        .op_attr   (op_attr),
        .key_on    (key_on),
        .restart   (restart),
        .op_sel    (op_sel),
        .frame_busy(frame_busy),
        .frame_done(frame_done),
        .out_stream(eng_stream.producer)
    );

    fm_sample_fifo #(.fifo_depth(fifo_depth)) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_stream (eng_stream.consumer),
        .out_stream(mix_stream.producer)
    );

    fm_mixer u_mixer (
        .clk      (clk),
        .reset    (reset),
        .in_stream(mix_stream.consumer),
        .audio_l  (audio_l),
        .audio_r  (audio_r)
    );

endmodule

//--- fm_mixer.sv
`timescale 1ns/1ps

module fm_mixer (
    input  logic                      clk,
    input  logic                      reset,
    op_stream_if.consumer             in_stream,
    output logic [fm_pkg::audio_w-1:0] audio_l,
    output logic [fm_pkg::audio_w-1:0] audio_r
);

    localparam int max_out = 2 ** (fm_pkg::audio_w - 1) - 1;
    localparam int min_out = -(2 ** (fm_pkg::audio_w - 1));

    logic signed [fm_pkg::accum_w-1:0] accum_l;
    logic signed [fm_pkg::accum_w-1:0] accum_r;
    logic signed [fm_pkg::accum_w-1:0] sample_ext;
    logic                              out_write;

    // Saturate a frame sum to the audio range
    function automatic logic [fm_pkg::audio_w-1:0] clamp(
        input logic signed [fm_pkg::accum_w-1:0] v
    );
        if (v > max_out)
            return (fm_pkg::audio_w)'(max_out);
        if (v < min_out)
            return (fm_pkg::audio_w)'(min_out);
        return v[fm_pkg::audio_w-1:0];
    endfunction

    assign sample_ext     = in_stream.sample;
    assign in_stream.hold = out_write;

    //////////////////////////////
    // Accumulate and publish
    //////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            accum_l   <= '0;
            accum_r   <= '0;
            out_write <= 1'b0;
            audio_l   <= '0;
            audio_r   <= '0;
        end else begin
            out_write <= 1'b0;
            if (out_write) begin
                audio_l <= clamp(accum_l);
                audio_r <= clamp(accum_r);
                accum_l <= '0;
                accum_r <= '0;
            end else if (in_stream.strobe) begin
                if (in_stream.to_left)
                    accum_l <= accum_l + sample_ext;
                if (in_stream.to_right)
                    accum_r <= accum_r + sample_ext;
                // Last operator of the frame
                if (in_stream.frame_end)
                    out_write <= 1'b1;
            end
        end
    end

    a_no_strobe_in_write: assert property (@(posedge clk) disable iff (reset)
        in_stream.hold |-> !in_stream.strobe);

endmodule

//--- fm_sample_fifo.sv
`timescale 1ns/1ps

module fm_sample_fifo #(
    parameter  int fifo_depth = 8,
    localparam int ptr_w      = $clog2(fifo_depth),
    localparam int cnt_w      = $clog2(fifo_depth + 1),
    localparam int entry_w    = fm_pkg::sample_w + 3
) (
    input  logic          clk,
    input  logic          reset,
    op_stream_if.consumer in_stream,
    op_stream_if.producer out_stream
);

    logic [entry_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    // Wraps for depths that are not a power of two
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
        return (p == (ptr_w)'(fifo_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = count == (cnt_w)'(fifo_depth);
    assign empty = count == '0;
    assign push  = in_stream.strobe;
    assign pop   = out_stream.strobe;

    assign in_stream.hold    = full;
    assign out_stream.strobe = !empty && !out_stream.hold;
    assign {out_stream.frame_end, out_stream.to_right, out_stream.to_left,
            out_stream.sample} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= {in_stream.frame_end, in_stream.to_right, in_stream.to_left,
                            in_stream.sample};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        in_stream.strobe |-> !full);

endmodule

//--- fm_operator_engine.sv
`timescale 1ns/1ps

module fm_operator_engine #(
    parameter  int num_channels = 8,
    parameter  int sample_div   = 64,
    localparam int op_w         = $clog2(2 * num_channels),
    localparam int div_w        = $clog2(sample_div)
) (
    input  logic             clk,
    input  logic             reset,
    input  fm_pkg::ch_attr_t ch_attr,
    input  fm_pkg::op_attr_t op_attr,
    input  logic             key_on,
    input  logic             restart,
    output logic [op_w-1:0]  op_sel,
    output logic             frame_busy,
    output logic             frame_done,
    op_stream_if.producer    out_stream
);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_push
    } state_t;

    state_t                             state;
    logic [div_w-1:0]                   div_cnt;
    logic                               div_pulse;
    logic                               pending;
    logic                               last_op;
    logic [fm_pkg::phase_w-1:0]         phase_mem [2*num_channels];
    logic [fm_pkg::phase_w-1:0]         base_step;
    logic [fm_pkg::phase_w-1:0]         step;
    logic [fm_pkg::phase_w-1:0]         next_phase;
    logic [9:0]                         mod;
    logic [9:0]                         wphase;
    logic [8:0]                         half_pos;
    logic [17:0]                        para;
    logic [11:0]                        sine_mag;
    logic [11:0]                        square_mag;
    logic [11:0]                        mag;
    logic signed [fm_pkg::sample_w-1:0] op_value;
    logic signed [fm_pkg::sample_w-1:0] op_out;

    //////////////////////////////
    // Sample divider
    //////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt   <= '0;
            div_pulse <= 1'b0;
        end else begin
            div_pulse <= 1'b0;
            if (div_cnt == (div_w)'(sample_div - 1)) begin
                div_cnt   <= '0;
                div_pulse <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Operator datapath
    //////////////////////////////
    // Half step when mult is zero
    assign base_step  = (fm_pkg::phase_w)'(ch_attr.fnum) << ch_attr.block;
    assign step       = (op_attr.mult == 4'd0) ? base_step >> 1 :
                        base_step * (fm_pkg::phase_w)'(op_attr.mult);
    assign next_phase = restart ? '0 : phase_mem[op_sel] + step;

    // Operator 1 takes the held output of operator 0 in serial mode
    assign mod    = (!ch_attr.alg && op_sel[0]) ? op_out[9:0] : 10'd0;
    assign wphase = next_phase[fm_pkg::phase_w-1 -: 10] + mod;

    // Parabola over each half period, peak near 4080
    assign half_pos   = wphase[8:0];
    assign para       = half_pos * (9'd511 - half_pos);
    assign sine_mag   = 12'(para >> (4 + op_attr.tl));
    assign square_mag = 12'(fm_pkg::max_amp >> op_attr.tl);
    assign mag        = op_attr.wave ? square_mag : sine_mag;

    always_comb begin
        op_value = '0;
        if (key_on)
            op_value = wphase[9] ? -$signed({1'b0, mag}) : $signed({1'b0, mag});
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2 * num_channels; i++)
                phase_mem[i] <= '0;
        end else if (state == st_compute) begin
            phase_mem[op_sel] <= next_phase;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_compute)
            op_out <= op_value;
    end

    //////////////////////////////
    // Sequencer
    //////////////////////////////
    assign last_op = op_sel == (op_w)'(2 * num_channels - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= st_idle;
            op_sel  <= '0;
            pending <= 1'b0;
        end else begin
            // Keep a pulse that lands mid-frame
            if (div_pulse && state != st_idle)
                pending <= 1'b1;
            case (state)
                st_idle: begin
                    if (div_pulse || pending) begin
                        state   <= st_compute;
                        pending <= 1'b0;
                    end
                end
                st_compute: state <= st_push;
                st_push: begin
                    if (!out_stream.hold) begin
                        if (last_op) begin
                            state  <= st_idle;
                            op_sel <= '0;
                        end else begin
                            state  <= st_compute;
                            op_sel <= op_sel + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign frame_busy = state != st_idle;
    assign frame_done = state == st_push && !out_stream.hold && last_op;

    assign out_stream.strobe    = state == st_push && !out_stream.hold;
    assign out_stream.sample    = op_out;
    assign out_stream.to_left   = ch_attr.pan_l && (ch_attr.alg || op_sel[0]);
    assign out_stream.to_right  = ch_attr.pan_r && (ch_attr.alg || op_sel[0]);
    assign out_stream.frame_end = last_op;

    a_no_strobe_on_hold: assert property (@(posedge clk) disable iff (reset)
        out_stream.strobe |-> !out_stream.hold);

endmodule

//--- fm_regs.sv
`timescale 1ns/1ps

module fm_regs #(
    parameter  int num_channels = 8,
    localparam int op_w         = $clog2(2 * num_channels)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [7:0]       bus_addr,
    input  logic [31:0]      bus_wrdata,
    input  logic             bus_wren,
    output logic [31:0]      bus_rddata,
    output logic             bus_wait,
    input  logic [op_w-1:0]  op_sel,
    input  logic             frame_busy,
    input  logic             frame_done,
    output fm_pkg::ch_attr_t ch_attr,
    output fm_pkg::op_attr_t op_attr,
    output logic             key_on,
    output logic             restart
);

    logic [7:0]              ch_off;
    logic [7:0]              op_off;
    logic                    sel_kon;
    logic                    sel_ch;
    logic                    sel_op;
    logic                    bus_wr;
    logic [op_w-2:0]         ch_sel;
    logic [31:0]             kon;
    logic [num_channels-1:0] kon_rise;
    logic [num_channels-1:0] restart_q;
    fm_pkg::ch_attr_t        ch_mem [num_channels];
    fm_pkg::op_attr_t        op_mem [2*num_channels];
    fm_pkg::ch_attr_t        rd_ch;
    fm_pkg::op_attr_t        rd_op;

    //////////////////////////////
    // Address decode
    //////////////////////////////
    // Offsets wrap below the window base, so one compare per window
    assign ch_off  = bus_addr - fm_pkg::ch_base;
    assign op_off  = bus_addr - fm_pkg::op_base;
    assign sel_kon = bus_addr == fm_pkg::addr_kon;
    assign sel_ch  = ch_off < 8'(num_channels);
    assign sel_op  = op_off < 8'(2 * num_channels);

    // Writes stall while the engine walks the operators
    assign bus_wait = bus_wren && frame_busy;
    assign bus_wr   = bus_wren && !frame_busy;

    // Channels whose key-on bit goes from 0 to 1
    assign kon_rise = (bus_wr && sel_kon) ?
                      bus_wrdata[num_channels-1:0] & ~kon[num_channels-1:0] : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            kon       <= '0;
            restart_q <= '0;
        end else begin
            if (bus_wr && sel_kon)
                kon <= bus_wrdata;
            restart_q <= (frame_done ? '0 : restart_q) | kon_rise;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_wr && sel_ch)
            ch_mem[ch_off[op_w-2:0]] <= {bus_wrdata[21], bus_wrdata[20], bus_wrdata[16],
                                         bus_wrdata[12:10], bus_wrdata[9:0]};
        if (bus_wr && sel_op)
            op_mem[op_off[op_w-1:0]] <= {bus_wrdata[11:8], bus_wrdata[7:4], bus_wrdata[0]};
    end

    //////////////////////////////
    // Readback
    //////////////////////////////
    assign rd_ch = ch_mem[ch_off[op_w-2:0]];
    assign rd_op = op_mem[op_off[op_w-1:0]];

    always_comb begin
        bus_rddata = '0;
        if (sel_kon)
            bus_rddata = kon;
        else if (sel_ch)
            bus_rddata = {10'b0, rd_ch.pan_r, rd_ch.pan_l, 3'b0, rd_ch.alg, 3'b0,
                          rd_ch.block, rd_ch.fnum};
        else if (sel_op)
            bus_rddata = {20'b0, rd_op.tl, rd_op.mult, 3'b0, rd_op.wave};
    end

    // Attributes of the operator under service
    assign ch_sel  = op_sel[op_w-1:1];
    assign ch_attr = ch_mem[ch_sel];
    assign op_attr = op_mem[op_sel];
    assign key_on  = kon[ch_sel];
    assign restart = restart_q[ch_sel];

    a_wait_needs_wren: assert property (@(posedge clk) disable iff (reset)
        bus_wait |-> bus_wren);

endmodule

//--- op_stream_if.sv
`timescale 1ns/1ps

interface op_stream_if;

    // Driven by the sender
    logic                               strobe;
    logic signed [fm_pkg::sample_w-1:0] sample;
    logic                               to_left;
    logic                               to_right;
    logic                               frame_end;

    // Driven by the receiver, blocks new strobes
    logic                               hold;

    modport producer (
        output strobe, sample, to_left, to_right, frame_end,
        input  hold
    );

    modport consumer (
        input  strobe, sample, to_left, to_right, frame_end,
        output hold
    );

endinterface

//--- fm_pkg.sv
package fm_pkg;

    // Datapath widths
    localparam int sample_w = 13;
    localparam int audio_w  = 16;
    localparam int accum_w  = 20;
    localparam int phase_w  = 20;

    // Largest operator magnitude
    localparam int max_amp = 4095;

    //////////////////////////////
    // Register map
    //////////////////////////////
    localparam logic [7:0] addr_kon = 8'h00;
    localparam logic [7:0] ch_base  = 8'h20;
    localparam logic [7:0] op_base  = 8'h80;

    // Per-channel settings
    typedef struct packed {
        logic       pan_r;
        logic       pan_l;
        logic       alg;    // set for additive, clear for serial modulation
        logic [2:0] block;
        logic [9:0] fnum;
    } ch_attr_t;

    // Per-operator settings
    typedef struct packed {
        logic [3:0] tl;     // right shift applied to the amplitude
        logic [3:0] mult;
        logic       wave;   // square when set
    } op_attr_t;

endpackage
